/* hdl/decodePkg.sv */
// Shared opcodes, instruction formats and decode bundle types for the decode stage
package decodePkg;

	// ====================
	// Register numbers
	// ====================

	typedef logic [5:0] regspec_t;
	typedef logic [31:0] address_t;

	// Register 0 is never a real operand
	localparam regspec_t noReg = 6'd0;
	// JSR links into one of four registers starting at this number
	localparam regspec_t linkBase = 6'd56;
	// RTD always writes the return register
	localparam regspec_t returnReg = 6'd62;

	// ====================
	// Opcodes
	// ====================

	typedef enum logic [6:0] {
		OP_R2 = 7'd2, OP_ADDI = 7'd4, OP_SUBFI = 7'd5, OP_MULI = 7'd6, OP_CSR = 7'd7,
		OP_ANDI = 7'd8, OP_ORI = 7'd9, OP_EORI = 7'd10, OP_CMPI = 7'd11,
		OP_FLT2 = 7'd12, OP_FLT3 = 7'd13, OP_MULUI = 7'd14, OP_MOV = 7'd15,
		OP_DIVI = 7'd16, OP_SLTI = 7'd17, OP_DIVUI = 7'd24,
		OP_JSR = 7'd66, OP_RTD = 7'd69,
		OP_LDB = 7'd72, OP_LDBU = 7'd73, OP_LDW = 7'd74, OP_LDWU = 7'd75,
		OP_LDT = 7'd76, OP_LDTU = 7'd77, OP_LDO = 7'd78, OP_LDX = 7'd79,
		OP_STB = 7'd80, OP_STW = 7'd81, OP_STT = 7'd82, OP_STO = 7'd83
	} opcode_t;

	// Function codes of the R2 format
	typedef enum logic [6:0] {
		FN_ANDC = 7'd3, FN_ADD = 7'd4, FN_SUB = 7'd5, FN_MUL = 7'd6, FN_ORC = 7'd7,
		FN_AND = 7'd8, FN_OR = 7'd9, FN_EOR = 7'd10, FN_CMP = 7'd11,
		FN_NAND = 7'd12, FN_NOR = 7'd13, FN_MULU = 7'd14, FN_ENOR = 7'd15,
		FN_DIV = 7'd16, FN_MOD = 7'd17, FN_DIVU = 7'd24, FN_MODU = 7'd25,
		FN_MULH = 7'd26, FN_MULUH = 7'd27,
		FN_SEQ = 7'd32, FN_SNE = 7'd33, FN_SLT = 7'd34, FN_SLE = 7'd35,
		FN_SLTU = 7'd36, FN_SLEU = 7'd37
	} func_t;

	// ====================
	// Instruction formats
	// ====================

	// Every view keeps opcode, Rt and Ra at the same bit positions
	typedef struct packed {
		logic [24:0] body;
		opcode_t opcode;
	} anyFmt_t;

	typedef struct packed {
		func_t func;
		regspec_t rb;
		regspec_t ra;
		regspec_t rt;
		opcode_t opcode;
	} r2Fmt_t;

	typedef struct packed {
		logic [12:0] imm;
		regspec_t ra;
		regspec_t rt;
		opcode_t opcode;
	} riFmt_t;

	// For stores the rt position carries the data register
	typedef struct packed {
		logic [12:0] disp;
		regspec_t ra;
		regspec_t rt;
		opcode_t opcode;
	} lsFmt_t;

	typedef struct packed {
		logic [6:0] fltFunc;
		regspec_t rb;
		regspec_t ra;
		regspec_t rt;
		opcode_t opcode;
	} f2Fmt_t;

	typedef struct packed {
		logic fltOp;
		regspec_t rc;
		regspec_t rb;
		regspec_t ra;
		regspec_t rt;
		opcode_t opcode;
	} f3Fmt_t;

	typedef struct packed {
		logic [12:0] csrNo;
		regspec_t ra;
		regspec_t rt;
		opcode_t opcode;
	} csrFmt_t;

	typedef union packed {
		anyFmt_t any;
		r2Fmt_t r2;
		riFmt_t ri;
		lsFmt_t ls;
		f2Fmt_t f2;
		f3Fmt_t f3;
		csrFmt_t csr;
	} instruction_t;

	// ====================
	// Stage payloads
	// ====================

	// Word entering from fetch
	typedef struct packed {
		instruction_t instr;
		address_t pc;
	} fetchWord_t;

	// Register specifiers and class flags handed to the next stage
	typedef struct packed {
		address_t pc;
		instruction_t instr;
		regspec_t rt;
		regspec_t ra;
		regspec_t rb;
		regspec_t rc;
		logic isAlu;
		logic isLoad;
		logic isStore;
		logic isBranch;
		logic isFlt;
		logic writesRt;
		logic illegal;
	} decodeBundle_t;

	// True for every opcode the decoder knows about
	function automatic logic knownOpcode(input opcode_t op);
		return op inside {OP_R2, OP_FLT2, OP_FLT3, OP_JSR, OP_RTD, OP_ADDI, OP_SUBFI,
			OP_CMPI, OP_MULI, OP_DIVI, OP_SLTI, OP_MULUI, OP_DIVUI, OP_ANDI, OP_ORI,
			OP_EORI, OP_CSR, OP_MOV, OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT, OP_LDTU,
			OP_LDO, OP_LDX, OP_STB, OP_STW, OP_STT, OP_STO};
	endfunction

	// True for the R2 function codes that produce a result
	function automatic logic knownFunc(input func_t fn);
		return fn inside {FN_ADD, FN_CMP, FN_MUL, FN_DIV, FN_SUB, FN_MULU, FN_DIVU,
			FN_MULH, FN_MOD, FN_MULUH, FN_MODU, FN_AND, FN_OR, FN_EOR, FN_ANDC, FN_NAND,
			FN_NOR, FN_ENOR, FN_ORC, FN_SEQ, FN_SNE, FN_SLT, FN_SLE, FN_SLTU, FN_SLEU};
	endfunction

endpackage

/* hdl/pipeReg.sv */
// One-entry valid/ready pipeline register carrying a payload of any packed type
module pipeReg #(
	parameter type payload_t = logic [31:0]
) (
	input logic clk,
	input logic rst,
	input logic inValid,
	output logic inReady,
	input payload_t inData,
	output logic outValid,
	input logic outReady,
	output payload_t outData
);

	logic loadEn;

	// ====================
	// Handshake
	// ====================

	// Accept when empty, or when the held entry leaves in this same cycle
	assign inReady = !outValid || outReady;

	// A new entry is taken on every upstream transfer
	assign loadEn = inValid && inReady;

	// ====================
	// Storage
	// ====================

	// Valid follows the upstream whenever the slot is free or draining
	always_ff @(posedge clk)
	begin
		if (rst)
			outValid <= 1'b0;
		else if (inReady)
			outValid <= inValid;
	end

	// Payload only moves on a transfer so it stays stable while stalled
	always_ff @(posedge clk)
	begin
		if (loadEn)
			outData <= inData;
	end

endmodule

/* hdl/decodeRt.sv */
// Destination register decoder, including the link registers implied by JSR and RTD
module decodeRt import decodePkg::*; (
	input instruction_t instr,
	output regspec_t rt
);

	opcode_t op;

	assign op = instr.any.opcode;

	// ====================
	// Rt selection
	// ====================

	always_comb
	begin
		case (op)
		// Link rule is listed first so that JSR never falls into the Rt field rule
		OP_JSR:
			rt = linkBase + regspec_t'(instr[8:7]);
		// RTD writes the fixed return register
		OP_RTD:
			rt = returnReg;
		// Only result-producing function codes write Rt
		OP_R2:
			if (knownFunc(instr.r2.func))
				rt = instr.r2.rt;
			else
				rt = noReg;
		OP_FLT2:
			rt = instr.f2.rt;
		OP_FLT3:
			rt = instr.f3.rt;
		// Immediate ALU operations
		OP_ADDI, OP_SUBFI, OP_CMPI, OP_MULI, OP_DIVI, OP_SLTI,
		OP_MULUI, OP_DIVUI, OP_ANDI, OP_ORI, OP_EORI:
			rt = instr.ri.rt;
		// CSR reads return the old value in Rt
		OP_CSR:
			rt = instr.csr.rt;
		OP_MOV:
			rt = instr.r2.rt;
		// Every load width writes its target register
		OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT, OP_LDTU, OP_LDO, OP_LDX:
			rt = instr.ls.rt;
		// Stores and unknown opcodes have no destination
		default:
			rt = noReg;
		endcase
	end

endmodule

/* hdl/decodeSrc.sv */
// Source register decoder for the Ra, Rb and Rc read ports
module decodeSrc import decodePkg::*; (
	input instruction_t instr,
	output regspec_t ra,
	output regspec_t rb,
	output regspec_t rc
);

	opcode_t op;

	assign op = instr.any.opcode;

	// ====================
	// Ra port
	// ====================

	// All known formats read Ra except the two branch forms
	assign ra = (knownOpcode(op) && !(op inside {OP_JSR, OP_RTD})) ? instr.r2.ra : noReg;

	// ====================
	// Rb and Rc ports
	// ====================

	always_comb
	begin
		case (op)
		OP_R2:
		begin
			rb = instr.r2.rb;
			rc = noReg;
		end
		OP_FLT2:
		begin
			rb = instr.f2.rb;
			rc = noReg;
		end
		// Three-operand float reads all three source ports
		OP_FLT3:
		begin
			rb = instr.f3.rb;
			rc = instr.f3.rc;
		end
		// Store data comes from the Rt position and is read on the Rc port
		OP_STB, OP_STW, OP_STT, OP_STO:
		begin
			rb = noReg;
			rc = instr.ls.rt;
		end
		default:
		begin
			rb = noReg;
			rc = noReg;
		end
		endcase
	end

endmodule

/* hdl/decodeClass.sv */
// Instruction class decoder that also flags illegal opcodes and function codes
module decodeClass import decodePkg::*; (
	input instruction_t instr,
	output logic isAlu,
	output logic isLoad,
	output logic isStore,
	output logic isBranch,
	output logic isFlt,
	output logic illegal
);

	opcode_t op;

	assign op = instr.any.opcode;

	// ====================
	// Class flags
	// ====================

	// Register, immediate and move forms all go to the integer ALU
	assign isAlu = op inside {OP_R2, OP_ADDI, OP_SUBFI, OP_CMPI, OP_MULI, OP_DIVI,
		OP_SLTI, OP_MULUI, OP_DIVUI, OP_ANDI, OP_ORI, OP_EORI, OP_MOV};

	// Memory groups by opcode
	assign isLoad = op inside {OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT, OP_LDTU,
		OP_LDO, OP_LDX};
	assign isStore = op inside {OP_STB, OP_STW, OP_STT, OP_STO};

	// Subroutine call and return are the only flow changes here
	assign isBranch = op inside {OP_JSR, OP_RTD};

	assign isFlt = op inside {OP_FLT2, OP_FLT3};

	// ====================
	// Illegal detection
	// ====================

	// An R2 word is only legal with one of the known function codes
	assign illegal = !knownOpcode(op) || (op == OP_R2 && !knownFunc(instr.r2.func));

endmodule

/* hdl/decodeTop.sv */
// Register-specifier decode stage between an input and an output pipeline register
module decodeTop import decodePkg::*; (
	input logic clk,
	input logic rst,
	input logic inValid,
	output logic inReady,
	input fetchWord_t inWord,
	output logic outValid,
	input logic outReady,
	output decodeBundle_t outBundle
);

	// Input register to decoders
	fetchWord_t stageWord;
	logic stageValid;
	logic stageReady;

	// Decoder results
	regspec_t rt;
	regspec_t ra;
	regspec_t rb;
	regspec_t rc;
	logic isAlu;
	logic isLoad;
	logic isStore;
	logic isBranch;
	logic isFlt;
	logic illegal;
	decodeBundle_t bundle;

	// ====================
	// Input register
	// ====================

	pipeReg #(.payload_t(fetchWord_t)) inStage (
		.clk(clk), .rst(rst),
		.inValid(inValid), .inReady(inReady), .inData(inWord),
		.outValid(stageValid), .outReady(stageReady), .outData(stageWord)
	);

	// ====================
	// Decoders
	// ====================

	decodeRt rtDec (.instr(stageWord.instr), .rt(rt));

	decodeSrc srcDec (.instr(stageWord.instr), .ra(ra), .rb(rb), .rc(rc));

	decodeClass classDec (
		.instr(stageWord.instr), .isAlu(isAlu), .isLoad(isLoad), .isStore(isStore),
		.isBranch(isBranch), .isFlt(isFlt), .illegal(illegal)
	);

	// The bundle carries the word along with its decoded fields
	assign bundle = '{pc: stageWord.pc, instr: stageWord.instr, rt: rt, ra: ra, rb: rb,
		rc: rc, isAlu: isAlu, isLoad: isLoad, isStore: isStore, isBranch: isBranch,
		isFlt: isFlt, writesRt: (rt != noReg), illegal: illegal};

	// ====================
	// Output register
	// ====================

	// Its ready feeds back to stall the input register
	pipeReg #(.payload_t(decodeBundle_t)) outStage (
		.clk(clk), .rst(rst),
		.inValid(stageValid), .inReady(stageReady), .inData(bundle),
		.outValid(outValid), .outReady(outReady), .outData(outBundle)
	);

endmodule

/* testbench/decodeTop_properties.sv */
// Handshake and reset assertions for both streams of the decode stage
module decodeTop_properties import decodePkg::*; (
	input logic clk,
	input logic rst,
	input logic inValid,
	input logic inReady,
	input fetchWord_t inWord,
	input logic outValid,
	input logic outReady,
	input decodeBundle_t outBundle
);

	// Count of failed assertions
	int assertFails = 0;

	// ====================
	// Input stream
	// ====================

	// A stalled word stays offered and unchanged
	inHeld: assert property (@(posedge clk) disable iff (rst)
		inValid && !inReady |=> inValid && $stable(inWord))
	else
	begin
		$error("input word dropped or changed while stalled");
		assertFails++;
	end

	// ====================
	// Output stream
	// ====================

	outHeld: assert property (@(posedge clk) disable iff (rst)
		outValid && !outReady |=> outValid && $stable(outBundle))
	else
	begin
		$error("output bundle dropped or changed while stalled");
		assertFails++;
	end

	// Reset empties the output register by the next edge
	outClear: assert property (@(posedge clk) rst |=> !outValid)
	else
	begin
		$error("outValid high in the cycle after reset");
		assertFails++;
	end

endmodule

bind decodeTop decodeTop_properties props (
	.clk(clk), .rst(rst), .inValid(inValid), .inReady(inReady), .inWord(inWord),
	.outValid(outValid), .outReady(outReady), .outBundle(outBundle)
);

/* testbench/decodeTb.sv */
// Directed testbench for the decode stage with a reference decode model and scoreboard
module decodeTb import decodePkg::*; ();

	// Words pushed by each test, used to size the watchdog
	localparam int r2Words = 28;
	localparam int fmtWords = 56;
	localparam int branchWords = 6;
	localparam int streamWords = 16;
	localparam int bpWords = 20;
	localparam int resetWords = 6;
	localparam int totalWords = r2Words + fmtWords + branchWords + streamWords + bpWords +
		resetWords;
	localparam int timeoutCycles = totalWords * 20 + 100;
	localparam int drainLimit = 100;

	// Result-producing R2 function codes
	localparam logic [6:0] funcList [25] = '{FN_ADD, FN_CMP, FN_MUL, FN_DIV, FN_SUB, FN_MULU,
		FN_DIVU, FN_MULH, FN_MOD, FN_MULUH, FN_MODU, FN_AND, FN_OR, FN_EOR, FN_ANDC, FN_NAND,
		FN_NOR, FN_ENOR, FN_ORC, FN_SEQ, FN_SNE, FN_SLT, FN_SLE, FN_SLTU, FN_SLEU};
	// Every opcode except R2, JSR and RTD
	localparam logic [6:0] fmtOps [27] = '{OP_ADDI, OP_SUBFI, OP_CMPI, OP_MULI, OP_DIVI,
		OP_SLTI, OP_MULUI, OP_DIVUI, OP_ANDI, OP_ORI, OP_EORI, OP_CSR, OP_MOV, OP_LDB, OP_LDBU,
		OP_LDW, OP_LDWU, OP_LDT, OP_LDTU, OP_LDO, OP_LDX, OP_STB, OP_STW, OP_STT, OP_STO,
		OP_FLT2, OP_FLT3};

	logic clk = 1'b0;
	logic rst;
	logic inValid;
	logic inReady;
	fetchWord_t inWord;
	logic outValid;
	logic outReady;
	decodeBundle_t outBundle;

	// Scoreboard state
	decodeBundle_t expQ [$];
	decodeBundle_t seenExp;
	int acceptQ [$];
	int latencyQ [$];
	int outCycleQ [$];
	int cycle = 0;
	int stallCycles = 0;
	int errors = 0;
	int checks = 0;
	int testErrors = 0;
	int testsRun = 0;
	int testsFailed = 0;
	string testName = "reset";
	logic [31:0] seed = 32'hea34aa9f;
	logic [31:0] nextPc = 32'h0000_1000;

	decodeTop DUT (
		.clk(clk), .rst(rst), .inValid(inValid), .inReady(inReady), .inWord(inWord),
		.outValid(outValid), .outReady(outReady), .outBundle(outBundle)
	);

	always #5 clk = ~clk;

	always @(posedge clk)
		cycle <= cycle + 1;

	// ====================
	// Helpers
	// ====================

	// Linear congruential generator for the random register fields
	function automatic logic [31:0] nextRand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// Builds a word from an opcode and the 25 bits above it, with a fresh pc
	function automatic fetchWord_t makeWord(input logic [6:0] op, input logic [24:0] body);
		fetchWord_t w;
		w.instr = {body, op};
		w.pc = nextPc;
		nextPc = nextPc + 32'd4;
		return w;
	endfunction

	// Expected bundle, worked out from the field positions and decode rules
	function automatic decodeBundle_t refDecode(input fetchWord_t w);
		decodeBundle_t b;
		logic [31:0] bits;
		logic [6:0] op;
		logic fnOk;
		logic opOk;
		logic isImm;
		logic isLd;
		logic isSt;
		bits = w.instr;
		op = bits[6:0];
		fnOk = bits[31:25] inside {FN_ADD, FN_CMP, FN_MUL, FN_DIV, FN_SUB, FN_MULU, FN_DIVU,
			FN_MULH, FN_MOD, FN_MULUH, FN_MODU, FN_AND, FN_OR, FN_EOR, FN_ANDC, FN_NAND,
			FN_NOR, FN_ENOR, FN_ORC, FN_SEQ, FN_SNE, FN_SLT, FN_SLE, FN_SLTU, FN_SLEU};
		isImm = op inside {OP_ADDI, OP_SUBFI, OP_CMPI, OP_MULI, OP_DIVI, OP_SLTI, OP_MULUI,
			OP_DIVUI, OP_ANDI, OP_ORI, OP_EORI};
		isLd = op inside {OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT, OP_LDTU, OP_LDO, OP_LDX};
		isSt = op inside {OP_STB, OP_STW, OP_STT, OP_STO};
		opOk = isImm || isLd || isSt ||
			(op inside {OP_R2, OP_FLT2, OP_FLT3, OP_JSR, OP_RTD, OP_CSR, OP_MOV});
		b = '0;
		b.pc = w.pc;
		b.instr = w.instr;
		// JSR links into one of four registers picked by bits 8 to 7
		if (op == OP_JSR)
			b.rt = linkBase + {4'd0, bits[8:7]};
		else if (op == OP_RTD)
			b.rt = returnReg;
		else if ((op == OP_R2 && fnOk) || isImm || isLd ||
			(op inside {OP_FLT2, OP_FLT3, OP_CSR, OP_MOV}))
			b.rt = bits[12:7];
		if (opOk && !(op inside {OP_JSR, OP_RTD}))
			b.ra = bits[18:13];
		if (op inside {OP_R2, OP_FLT2, OP_FLT3})
			b.rb = bits[24:19];
		// Store data sits in the Rt position and is read on Rc
		if (op == OP_FLT3)
			b.rc = bits[30:25];
		else if (isSt)
			b.rc = bits[12:7];
		b.isAlu = op == OP_R2 || isImm || op == OP_MOV;
		b.isLoad = isLd;
		b.isStore = isSt;
		b.isBranch = op == OP_JSR || op == OP_RTD;
		b.isFlt = op == OP_FLT2 || op == OP_FLT3;
		b.writesRt = b.rt != 6'd0;
		b.illegal = !opOk || (op == OP_R2 && !fnOk);
		return b;
	endfunction

	task automatic checkValue(input string what, input logic [127:0] expected,
		input logic [127:0] actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("error %s: %s expected %h actual %h", testName, what, expected, actual);
		end
	endtask

	task automatic beginTest(input string name);
		testName = name;
		testErrors = errors;
	endtask

	task automatic endTest();
		testsRun++;
		if (errors == testErrors)
			$display("test %s: ok", testName);
		else
		begin
			testsFailed++;
			$display("test %s: %0d errors", testName, errors - testErrors);
		end
	endtask

	// ====================
	// Stream driving
	// ====================

	// Offers one word and holds it until the DUT takes it
	task automatic sendWord(input fetchWord_t w);
		logic taken;
		taken = 1'b0;
		inWord = w;
		inValid = 1'b1;
		expQ.push_back(refDecode(w));
		while (!taken)
		begin
			@(negedge clk);
			taken = inReady;
			@(posedge clk);
			#1;
		end
	endtask

	// Waits until every expected bundle has come out
	task automatic waitDrain();
		int waited;
		waited = 0;
		inValid = 1'b0;
		while ((expQ.size() != 0 || outValid) && waited < drainLimit)
		begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (expQ.size() != 0)
		begin
			errors++;
			$display("%s: %0d expected bundles never came out", testName, expQ.size());
		end
	endtask

	task automatic applyReset(input int cycles);
		rst = 1'b1;
		inValid = 1'b0;
		repeat (cycles) @(posedge clk);
		#1;
		// Words still in flight are lost on purpose
		expQ.delete();
		acceptQ.delete();
		rst = 1'b0;
	endtask

	task automatic checkIdle(input string when);
		@(negedge clk);
		checkValue({when, " outValid"}, 128'(1'b0), 128'(outValid));
		checkValue({when, " inReady"}, 128'(1'b1), 128'(inReady));
		@(posedge clk);
		#1;
	endtask

	// Scoreboard, sampled at the falling edge where both streams are settled
	always @(negedge clk)
	begin
		if (!rst)
		begin
			if (inValid && inReady)
				acceptQ.push_back(cycle);
			if (inValid && !inReady)
				stallCycles++;
			if (outValid && outReady)
			begin
				if (expQ.size() == 0)
				begin
					errors++;
					$display("%s: a bundle came out with no word pending", testName);
				end
				else
				begin
					seenExp = expQ.pop_front();
					checkValue("bundle", 128'(seenExp), 128'(outBundle));
					if (acceptQ.size() != 0)
						latencyQ.push_back(cycle - acceptQ.pop_front());
					outCycleQ.push_back(cycle);
				end
			end
		end
	end

	// ====================
	// Tests
	// ====================

	task automatic r2Test();
		logic [31:0] r;
		beginTest("r2");
		for (int i = 0; i < 25; i++)
		begin
			r = nextRand();
			sendWord(makeWord(OP_R2, {funcList[i], r[17:0]}));
		end
		// Codes outside the list decode as illegal with no destination
		r = nextRand();
		sendWord(makeWord(OP_R2, {7'd0, r[17:0]}));
		sendWord(makeWord(OP_R2, {7'd1, r[17:0]}));
		sendWord(makeWord(OP_R2, {7'd127, r[17:0]}));
		waitDrain();
		endTest();
	endtask

	task automatic formatTest();
		logic [31:0] r;
		beginTest("formats");
		for (int i = 0; i < 27; i++)
		begin
			repeat (2)
			begin
				r = nextRand();
				sendWord(makeWord(fmtOps[i], r[31:7]));
			end
		end
		r = nextRand();
		sendWord(makeWord(7'd0, r[31:7]));
		sendWord(makeWord(7'd127, r[31:7]));
		waitDrain();
		endTest();
	endtask

	task automatic branchTest();
		logic [31:0] r;
		beginTest("branch");
		for (int k = 0; k < 4; k++)
		begin
			r = nextRand();
			sendWord(makeWord(OP_JSR, {r[31:9], 2'(k)}));
		end
		repeat (2)
		begin
			r = nextRand();
			sendWord(makeWord(OP_RTD, r[31:7]));
		end
		waitDrain();
		endTest();
	endtask

	task automatic streamTest();
		logic [31:0] r;
		beginTest("stream");
		latencyQ.delete();
		outCycleQ.delete();
		outReady = 1'b1;
		for (int i = 0; i < streamWords; i++)
		begin
			r = nextRand();
			sendWord(makeWord(fmtOps[i], r[31:7]));
		end
		waitDrain();
		checkValue("outputs", 128'(streamWords), 128'(latencyQ.size()));
		// Visible two edges after acceptance, then one bundle every cycle
		for (int i = 0; i < latencyQ.size(); i++)
		begin
			checkValue("latency", 128'(2), 128'(latencyQ[i]));
			if (i > 0)
				checkValue("spacing", 128'(1), 128'(outCycleQ[i] - outCycleQ[i - 1]));
		end
		endTest();
	endtask

	task automatic backPressureTest();
		logic [31:0] r;
		logic [7:0] pattern;
		beginTest("backPressure");
		stallCycles = 0;
		pattern = 8'b0001_1011;
		fork
			begin
				for (int i = 0; i < bpWords; i++)
				begin
					r = nextRand();
					sendWord(makeWord(fmtOps[26 - i], r[31:7]));
				end
				inValid = 1'b0;
			end
			begin
				// Rotating pattern with a run of three low cycles that fills both stages
				repeat (60)
				begin
					outReady = pattern[0];
					pattern = {pattern[0], pattern[7:1]};
					@(posedge clk);
					#1;
				end
				outReady = 1'b1;
			end
		join
		waitDrain();
		checkValue("inReady fell", 128'(1'b1), 128'(stallCycles > 0));
		endTest();
	endtask

	task automatic resetTest();
		logic [31:0] r;
		beginTest("reset");
		outReady = 1'b1;
		applyReset(5);
		checkIdle("after reset");
		for (int i = 0; i < resetWords / 2; i++)
		begin
			r = nextRand();
			sendWord(makeWord(fmtOps[i], r[31:7]));
		end
		// Reset lands with words still in both stages
		applyReset(5);
		checkIdle("after mid-stream reset");
		for (int i = 0; i < resetWords / 2; i++)
		begin
			r = nextRand();
			sendWord(makeWord(OP_R2, {funcList[i], r[17:0]}));
		end
		waitDrain();
		endTest();
	endtask

	// ====================
	// Run control
	// ====================

	initial
	begin
		#(timeoutCycles * 10);
		$display("timeout: the tests did not finish within %0d cycles", timeoutCycles);
		$display("sim failed");
		$finish;
	end

	initial
	begin
		rst = 1'b1;
		inValid = 1'b0;
		inWord = '0;
		outReady = 1'b1;
		applyReset(5);
		r2Test();
		formatTest();
		branchTest();
		streamTest();
		backPressureTest();
		resetTest();
		$display("%0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
			testsRun, testsFailed, checks, errors, DUT.props.assertFails);
		if (errors == 0 && testsFailed == 0 && DUT.props.assertFails == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

/* verilog.f */
hdl/decodePkg.sv
hdl/pipeReg.sv
hdl/decodeRt.sv
hdl/decodeSrc.sv
hdl/decodeClass.sv
hdl/decodeTop.sv
testbench/decodeTop_properties.sv
testbench/decodeTb.sv

/* Makefile */
# Verilator build and run of the decode stage testbench

TOP = decodeTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 -f verilog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	@grep -q "^sim passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
